/* design/sfu_pkg.sv */
// sfu shared definitions
// widths, mode encodings and the row entry carried through the buffers
`default_nettype none

package sfu_pkg;

  // columns per row from the systolic array
  localparam int COL = 8;

  // partial-sum width, 2*4 + 4 guard bits
  localparam int BW_PSUM = 12;

  // row sum, eight 12-bit magnitudes need 15 bits, kept at 16
  localparam int SUM_W = 16;

  // own row sum plus the other core's row sum
  localparam int TOTAL_W = SUM_W + 1;

  // fixed-point scale of the normalized result
  localparam int NORM_SHIFT = 12;

  // width-8 mode packs two columns into one value
  localparam int PAIRS = COL / 2;
  localparam int WIDE_W = 2 * BW_PSUM;

  // one column value
  typedef logic [BW_PSUM-1:0] psum_t;

  // one row, column 0 in the low bits
  typedef psum_t [COL-1:0] psum_vec_t;

  // row sum of one core
  typedef logic [SUM_W-1:0] row_sum_t;

  // total across both cores
  typedef logic [TOTAL_W-1:0] total_t;

  // operand width of the array
  typedef enum logic {
    WIDTH_4 = 1'b0,
    WIDTH_8 = 1'b1
  } width_mode_e;

  // column interpretation
  typedef enum logic {
    UNSIGNED = 1'b0,
    SIGNED   = 1'b1
  } sign_mode_e;

  // mode pins grouped, width in the upper bit
  typedef struct packed {
    width_mode_e width;
    sign_mode_e  sign;
  } sfu_mode_t;

  // one buffered row
  // values hold magnitudes in width-4, packed pairs in width-8
  typedef struct packed {
    row_sum_t  sum;
    psum_vec_t values;
  } sfu_entry_t;

endpackage

`default_nettype wire

/* design/sfu_input_stage.sv */
// sfu input stage
// column magnitudes, row-sum adder tree and width-8 pair packing
`timescale 1ns/1ps
`default_nettype none

module sfu_input_stage import sfu_pkg::*; (
  input  psum_vec_t  sfp_in,
  input  sfu_mode_t  mode,
  output sfu_entry_t entry
);

  // upper column of a pair sits one nibble above the lower
  localparam int PACK_SHIFT = 4;

  // pad bits from a 12-bit column up to a 24-bit pair value
  localparam int EXT_W = WIDE_W - BW_PSUM;

  psum_vec_t                    mag;
  logic [PAIRS-1:0][BW_PSUM:0]  pair_sum;
  logic [1:0][BW_PSUM+1:0]      half_sum;
  row_sum_t                     row_sum;
  logic [PAIRS-1:0][WIDE_W-1:0] wide_val;
  psum_vec_t                    values;

  // magnitude per column
  always_comb begin
    for (int c = 0; c < COL; c++) begin
      // two's complement negate only for negative signed values
      if (mode.sign == SIGNED && sfp_in[c][BW_PSUM-1]) begin
        mag[c] = ~sfp_in[c] + 1'b1;
      end else begin
        mag[c] = sfp_in[c];
      end
    end
  end

  // first tree level, adjacent columns
  always_comb begin
    for (int p = 0; p < PAIRS; p++) begin
      pair_sum[p] = mag[2*p] + mag[2*p+1];
    end
  end

  // second tree level, adjacent pair sums
  always_comb begin
    for (int h = 0; h < 2; h++) begin
      half_sum[h] = pair_sum[2*h] + pair_sum[2*h+1];
    end
  end

  // root add, carry lands inside 16 bits
  assign row_sum = half_sum[0] + half_sum[1];

  // width-8 packing from the raw columns
  always_comb begin
    for (int p = 0; p < PAIRS; p++) begin
      logic              ext_hi;
      logic              ext_lo;
      logic [WIDE_W-1:0] hi;
      logic [WIDE_W-1:0] lo;
      // extension bit is the column msb in signed mode, zero otherwise
      ext_hi = (mode.sign == SIGNED) & sfp_in[2*p+1][BW_PSUM-1];
      ext_lo = (mode.sign == SIGNED) & sfp_in[2*p][BW_PSUM-1];
      hi = {{EXT_W{ext_hi}}, sfp_in[2*p+1]};
      lo = {{EXT_W{ext_lo}}, sfp_in[2*p]};
      // wraps modulo 2^24 like the array output
      wide_val[p] = (hi << PACK_SHIFT) + lo;
    end
  end

  // pair k lands on columns 2k and 2k+1
  assign values = (mode.width == WIDTH_8) ? psum_vec_t'(wide_val) : mag;

  // sum is the magnitude sum in both width modes
  assign entry.sum    = row_sum;
  assign entry.values = values;

endmodule

`default_nettype wire

/* design/sfu_fifo.sv */
// sfu buffer FIFO
// register array, show-ahead head, full and empty flags
`timescale 1ns/1ps
`default_nettype none

module sfu_fifo #(
  parameter int DATA_W     = 16,
  parameter int FIFO_DEPTH = 16
) (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              wr,
  input  logic              rd,
  input  logic [DATA_W-1:0] din,
  output logic [DATA_W-1:0] dout,
  output logic              empty,
  output logic              full
);

  // pointer needs at least one bit even for a single entry
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST = PTR_W'(FIFO_DEPTH - 1);

  logic [DATA_W-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [CNT_W-1:0]  count;
  logic              wr_en;
  logic              rd_en;

  // overflow writes and underflow reads are dropped here
  assign wr_en = wr & ~full;
  assign rd_en = rd & ~empty;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(FIFO_DEPTH));

  // head visible without a read
  assign dout = mem[rd_ptr];

  // storage
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= din;
    end
  end

  // pointers and occupancy
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/sfu_normalizer.sv */
// sfu normalizer
// two-core total and per-column fixed-point divide of the head row
`timescale 1ns/1ps
`default_nettype none

module sfu_normalizer import sfu_pkg::*; (
  input  sfu_entry_t head,
  input  row_sum_t   oc_sfu_sum,
  input  sfu_mode_t  mode,
  output psum_vec_t  sfp_out,
  output total_t     sum_out
);

  // magnitude scaled up before the divide
  localparam int DIVIDEND_W = BW_PSUM + NORM_SHIFT;

  total_t    total;
  psum_vec_t norm;

  // 17-bit add keeps the carry of two 16-bit sums
  assign total   = head.sum + oc_sfu_sum;
  assign sum_out = total;

  // one divider per column
  always_comb begin
    for (int c = 0; c < COL; c++) begin
      logic [DIVIDEND_W-1:0] dividend;
      logic [DIVIDEND_W-1:0] quotient;
      dividend = {head.values[c], {NORM_SHIFT{1'b0}}};
      // zero total saturates instead of dividing
      quotient = (total == '0) ? '1 : dividend / total;
      // only the low 12 bits are kept
      norm[c] = quotient[BW_PSUM-1:0];
    end
  end

  // width-8 rows pass through unnormalized
  // live mode, so mode must not change with rows still buffered
  assign sfp_out = (mode.width == WIDTH_8) ? head.values : norm;

endmodule

`default_nettype wire

/* design/sfu.sv */
// sfu top level
// buffers row sums and values, exchanges sums with the peer core, normalizes
`timescale 1ns/1ps
`default_nettype none

module sfu import sfu_pkg::*; #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      acc,
  input  logic      div,
  input  sfu_mode_t mode,
  input  psum_vec_t sfp_in,
  input  logic      oc_sfu_fifo_rd,
  input  logic      oc_sfu_fifo_empty,
  input  row_sum_t  oc_sfu_sum,
  output psum_vec_t sfp_out,
  output total_t    sum_out,
  output logic      tc_sfu_fifo_rd,
  output logic      tc_sfu_fifo_empty,
  output logic      ready,
  output row_sum_t  tc_sfu_sum
);

  sfu_entry_t entry;
  sfu_entry_t head;
  logic       entry_empty;

  // magnitudes, row sum and packing of the incoming row
  sfu_input_stage i_input_stage (
    .sfp_in (sfp_in),
    .mode   (mode),
    .entry  (entry)
  );

  // local row buffer, sum and values together
  // written on acc, popped on div
  sfu_fifo #(
    .DATA_W     ($bits(sfu_entry_t)),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) entry_fifo (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (acc),
    .rd     (div),
    .din    (entry),
    .dout   (head),
    .empty  (entry_empty),
    .full   ()
  );

  // row sums for the other core
  // it pops with its own read strobe
  sfu_fifo #(
    .DATA_W     (SUM_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) exchange_fifo (
    .clk    (clk),
    .arst_n (arst_n),
    .wr     (acc),
    .rd     (oc_sfu_fifo_rd),
    .din    (entry.sum),
    .dout   (tc_sfu_sum),
    .empty  (tc_sfu_fifo_empty),
    .full   ()
  );

  // head row over the combined total
  sfu_normalizer i_normalizer (
    .head       (head),
    .oc_sfu_sum (oc_sfu_sum),
    .mode       (mode),
    .sfp_out    (sfp_out),
    .sum_out    (sum_out)
  );

  // both heads present, so a div yields a valid result
  assign ready = ~entry_empty & ~oc_sfu_fifo_empty;

  // the peer pops its exchange head in step with our div
  assign tc_sfu_fifo_rd = div;

endmodule

`default_nettype wire

/* testbench/sfu_checker.sv */
// sfu checker
// scoreboard of buffered rows and exchange sums, compares DUT outputs every cycle
`timescale 1ns/1ps
`default_nettype none

module sfu_checker import sfu_pkg::*; #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      acc,
  input  logic      div,
  input  sfu_mode_t mode,
  input  psum_vec_t sfp_in,
  input  logic      oc_sfu_fifo_rd,
  input  logic      oc_sfu_fifo_empty,
  input  row_sum_t  oc_sfu_sum,
  input  psum_vec_t sfp_out,
  input  total_t    sum_out,
  input  logic      tc_sfu_fifo_rd,
  input  logic      tc_sfu_fifo_empty,
  input  logic      ready,
  input  row_sum_t  tc_sfu_sum,
  output int        check_count,
  output int        error_count
);

  // expected local rows and expected exchange sums, head at index 0
  sfu_entry_t entries[$];
  row_sum_t   sums[$];

  initial begin
    check_count = 0;
    error_count = 0;
  end

  task automatic compare_value(string name, logic [31:0] exp_v, logic [31:0] got_v);
    check_count++;
    if (exp_v !== got_v) begin
      error_count++;
      $display("** Error: %s expected %0h got %0h at %0t", name, exp_v, got_v, $time);
    end
  endtask

  // row as the buffer should hold it, built from the column rules
  function automatic sfu_entry_t expected_entry(psum_vec_t row, sfu_mode_t m);
    sfu_entry_t e;
    int         v;
    int         total;
    int         hi;
    int         lo;
    int         pair_val;
    total = 0;
    for (int c = 0; c < COL; c++) begin
      if (m.sign == SIGNED) begin
        v = $signed(row[c]);
      end else begin
        v = row[c];
      end
      // absolute value, -2048 gives 2048
      if (v < 0) begin
        v = -v;
      end
      e.values[c] = psum_t'(v);
      total += v;
    end
    e.sum = row_sum_t'(total);
    // width-8 pair k is col 2k+1 times 16 plus col 2k, kept mod 2^24
    if (m.width == WIDTH_8) begin
      for (int k = 0; k < PAIRS; k++) begin
        if (m.sign == SIGNED) begin
          hi = $signed(row[2*k+1]);
          lo = $signed(row[2*k]);
        end else begin
          hi = row[2*k+1];
          lo = row[2*k];
        end
        pair_val = hi * 16 + lo;
        e.values[2*k]   = pair_val[11:0];
        e.values[2*k+1] = pair_val[23:12];
      end
    end
    return e;
  endfunction

  // scaled magnitude over the two-core total, all ones on zero total
  function automatic psum_t expected_norm(psum_t value, int total);
    longint q;
    if (total == 0) begin
      return '1;
    end
    q = (longint'(value) << NORM_SHIFT) / total;
    return q[11:0];
  endfunction

  // sample at the rising edge, inputs settled since the falling edge
  always @(posedge clk or negedge arst_n) begin
    sfu_entry_t head;
    int         total;
    logic       push_entry;
    logic       push_sum;
    logic       pop_entry;
    logic       pop_sum;
    if (!arst_n) begin
      entries.delete();
      sums.delete();
    end else begin
      compare_value("ready", entries.size() > 0 && !oc_sfu_fifo_empty, ready);
      compare_value("tc_sfu_fifo_rd", div, tc_sfu_fifo_rd);
      compare_value("tc_sfu_fifo_empty", sums.size() == 0, tc_sfu_fifo_empty);
      if (sums.size() > 0) begin
        compare_value("tc_sfu_sum", sums[0], tc_sfu_sum);
      end
      if (entries.size() > 0) begin
        head = entries[0];
        if (mode.width == WIDTH_8) begin
          // packed pairs pass straight through
          for (int c = 0; c < COL; c++) begin
            compare_value($sformatf("sfp_out[%0d]", c), head.values[c], sfp_out[c]);
          end
        end else if (!oc_sfu_fifo_empty) begin
          total = int'(head.sum) + int'(oc_sfu_sum);
          compare_value("sum_out", total, sum_out);
          for (int c = 0; c < COL; c++) begin
            compare_value($sformatf("sfp_out[%0d]", c),
                          expected_norm(head.values[c], total), sfp_out[c]);
          end
        end
      end
      // full and empty decided on the occupancy before this edge
      push_entry = acc && entries.size() < FIFO_DEPTH;
      push_sum   = acc && sums.size() < FIFO_DEPTH;
      pop_entry  = div && entries.size() > 0;
      pop_sum    = oc_sfu_fifo_rd && sums.size() > 0;
      head = expected_entry(sfp_in, mode);
      if (pop_entry) begin
        void'(entries.pop_front());
      end
      if (pop_sum) begin
        void'(sums.pop_front());
      end
      if (push_entry) begin
        entries.push_back(head);
      end
      if (push_sum) begin
        sums.push_back(head.sum);
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/sfu_tb.sv */
// sfu testbench
// random row bursts in all four modes, peer core modelled as a queue of sums
`timescale 1ns/1ps
`default_nettype none

module sfu_tb import sfu_pkg::*; ();

  localparam int          FIFO_DEPTH  = 16;
  localparam int          NUM_BURSTS  = 40;
  localparam int          DRAIN_LIMIT = 500;
  localparam logic [31:0] SEED        = 32'h47345118;

  logic      clk;
  logic      arst_n;
  logic      acc;
  logic      div;
  sfu_mode_t mode;
  psum_vec_t sfp_in;
  logic      oc_sfu_fifo_rd;
  logic      oc_sfu_fifo_empty;
  row_sum_t  oc_sfu_sum;
  psum_vec_t sfp_out;
  total_t    sum_out;
  logic      tc_sfu_fifo_rd;
  logic      tc_sfu_fifo_empty;
  logic      ready;
  row_sum_t  tc_sfu_sum;
  int        check_count;
  int        error_count;

  // peer core exchange FIFO, head at index 0
  row_sum_t peer_q[$];
  int       outstanding;
  int       timeout_count;
  int       waited;
  int       seed_init;
  int       n_rows;

  sfu #(.FIFO_DEPTH(FIFO_DEPTH)) i_sfu (
    .clk (clk), .arst_n (arst_n), .acc (acc), .div (div), .mode (mode),
    .sfp_in (sfp_in), .oc_sfu_fifo_rd (oc_sfu_fifo_rd),
    .oc_sfu_fifo_empty (oc_sfu_fifo_empty), .oc_sfu_sum (oc_sfu_sum),
    .sfp_out (sfp_out), .sum_out (sum_out), .tc_sfu_fifo_rd (tc_sfu_fifo_rd),
    .tc_sfu_fifo_empty (tc_sfu_fifo_empty), .ready (ready), .tc_sfu_sum (tc_sfu_sum)
  );

  sfu_checker #(.FIFO_DEPTH(FIFO_DEPTH)) i_checker (
    .clk (clk), .arst_n (arst_n), .acc (acc), .div (div), .mode (mode),
    .sfp_in (sfp_in), .oc_sfu_fifo_rd (oc_sfu_fifo_rd),
    .oc_sfu_fifo_empty (oc_sfu_fifo_empty), .oc_sfu_sum (oc_sfu_sum),
    .sfp_out (sfp_out), .sum_out (sum_out), .tc_sfu_fifo_rd (tc_sfu_fifo_rd),
    .tc_sfu_fifo_empty (tc_sfu_fifo_empty), .ready (ready), .tc_sfu_sum (tc_sfu_sum),
    .check_count (check_count), .error_count (error_count)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // all-zero rows now and then, so a zero total can occur
  function automatic psum_vec_t random_row();
    psum_vec_t row;
    row = '0;
    if ($urandom % 8 != 0) begin
      for (int c = 0; c < COL; c++) begin
        row[c] = psum_t'($urandom);
      end
    end
    return row;
  endfunction

  function automatic row_sum_t random_peer_sum();
    return ($urandom % 8 == 0) ? '0 : row_sum_t'($urandom);
  endfunction

  // peer pops on our read strobe, reads our exchange FIFO at random
  task automatic advance_peer();
    if (tc_sfu_fifo_rd && peer_q.size() > 0) begin
      void'(peer_q.pop_front());
    end
    oc_sfu_fifo_rd = !tc_sfu_fifo_empty && ($urandom % 3 == 0);
  endtask

  task automatic drive_peer();
    oc_sfu_fifo_empty = (peer_q.size() == 0);
    oc_sfu_sum = (peer_q.size() == 0) ? '0 : peer_q[0];
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    advance_peer();
    acc = 1'b0;
    div = 1'b0;
    drive_peer();
  endtask

  // one row in, peer usually produces its sum alongside
  task automatic acc_cycle();
    @(negedge clk);
    advance_peer();
    acc = 1'b1;
    div = 1'b0;
    sfp_in = random_row();
    outstanding++;
    if ($urandom % 4 != 0 && peer_q.size() < FIFO_DEPTH) begin
      peer_q.push_back(random_peer_sum());
    end
    drive_peer();
  endtask

  initial begin
    seed_init = $urandom(SEED);
    arst_n = 1'b0;
    acc = 1'b0;
    div = 1'b0;
    mode = '0;
    sfp_in = '0;
    oc_sfu_fifo_rd = 1'b0;
    oc_sfu_fifo_empty = 1'b1;
    oc_sfu_sum = '0;
    outstanding = 0;
    timeout_count = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    for (int b = 0; b < NUM_BURSTS; b++) begin
      // mode steps through all four settings with the buffers empty
      idle_cycle();
      mode = sfu_mode_t'(b[1:0]);
      n_rows = 1 + $urandom % FIFO_DEPTH;
      for (int i = 0; i < n_rows; i++) begin
        repeat ($urandom % 3) idle_cycle();
        acc_cycle();
      end
      // divide phase, only while both heads are present
      waited = 0;
      while (outstanding > 0 && waited < DRAIN_LIMIT) begin
        @(negedge clk);
        advance_peer();
        acc = 1'b0;
        if (peer_q.size() == 0 && $urandom % 2 == 0) begin
          peer_q.push_back(random_peer_sum());
        end
        drive_peer();
        div = peer_q.size() > 0 && ($urandom % 3 != 0);
        if (div) begin
          outstanding--;
        end
        waited++;
      end
      if (outstanding > 0) begin
        $display("timeout: local rows still buffered after %0d cycles", DRAIN_LIMIT);
        timeout_count++;
        break;
      end
      // peer empties the exchange FIFO before the next mode
      waited = 0;
      do begin
        idle_cycle();
        waited++;
      end while (!tc_sfu_fifo_empty && waited < DRAIN_LIMIT);
      if (!tc_sfu_fifo_empty) begin
        $display("timeout: exchange FIFO not drained after %0d cycles", DRAIN_LIMIT);
        timeout_count++;
        break;
      end
    end
    repeat (2) idle_cycle();
    $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sfu.f */
design/sfu_pkg.sv
design/sfu_input_stage.sv
design/sfu_fifo.sv
design/sfu_normalizer.sv
design/sfu.sv
testbench/sfu_checker.sv
testbench/sfu_tb.sv

/* Bender.yml */
package:
  name: sfu

sources:
  - design/sfu_pkg.sv
  - design/sfu_input_stage.sv
  - design/sfu_fifo.sv
  - design/sfu_normalizer.sv
  - design/sfu.sv
  - target: test
    files:
      - testbench/sfu_checker.sv
      - testbench/sfu_tb.sv
